// File: design/keypad_consts.svh
`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// Key codes are {row, col}, both one-hot, R0 and C0 on the top bit
`define KP_KEY_NONE          8'b0000_0000 // No key pressed

`define KP_KEY_1             8'b1000_1000 // R0 C0, ignored
`define KP_KEY_2             8'b1000_0100 // R0 C1
`define KP_KEY_3             8'b1000_0010 // R0 C2
`define KP_KEY_A             8'b1000_0001 // R0 C3, ignored
`define KP_KEY_4             8'b0100_1000 // R1 C0
`define KP_KEY_5             8'b0100_0100 // R1 C1
`define KP_KEY_6             8'b0100_0010 // R1 C2
`define KP_KEY_B             8'b0100_0001 // R1 C3, ignored
`define KP_KEY_7             8'b0010_1000 // R2 C0, four letters
`define KP_KEY_8             8'b0010_0100 // R2 C1
`define KP_KEY_9             8'b0010_0010 // R2 C2, four letters
`define KP_KEY_GAME_END      8'b0010_0001 // R2 C3, key C
`define KP_KEY_SUBMIT_LETTER 8'b0001_1000 // R3 C0, star
`define KP_KEY_CLEAR         8'b0001_0100 // R3 C1, zero
`define KP_KEY_SUBMIT_WORD   8'b0001_0010 // R3 C2, hash
`define KP_KEY_D             8'b0001_0001 // R3 C3, ignored

// Word buffer depth
`define KP_MAX_LETTERS 8

// First upper-case letter
`define KP_ASCII_A 8'd65

`endif

// File: design/keypad_pkg.sv
`include "keypad_consts.svh"

package keypad_pkg;

  // One key code as seen on the matrix
  typedef struct packed {
    logic [3:0] row; // One-hot, R0 on bit 3
    logic [3:0] col; // One-hot, C0 on bit 3
  } key_t;

  // Tap FSM states
  // S0 to S3 count the taps on the current letter key
  typedef enum logic [2:0] {
    INIT = 3'd0,
    S0   = 3'd1,
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4,
    DONE = 3'd5  // Letter submitted
  } tap_state_t;

  // Completed word as handed out by the buffer
  typedef struct packed {
    logic [`KP_MAX_LETTERS-1:0][7:0] letters; // Letter 0 in element 0
    logic [3:0]                      len;     // Number of valid letters
    logic                            overflow; // Letters were dropped
  } word_t;

endpackage

// File: design/key_sync.sv
`timescale 1ns/100ps
`include "keypad_consts.svh"

module key_sync (
  input  logic             clk,
  input  logic             nRst,
  input  keypad_pkg::key_t key_in,  // Raw level from the keypad
  output logic             strobe,  // One cycle per new press
  output keypad_pkg::key_t cur_key  // Last pressed key, held
);

  keypad_pkg::key_t sync1; // First synchronizer stage
  keypad_pkg::key_t sync2; // Second stage, safe to use
  keypad_pkg::key_t prev;  // sync2 one cycle ago
  logic             press;

  // Press is the edge from no key to some key
  assign press = (sync2 != `KP_KEY_NONE) && (prev == `KP_KEY_NONE);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      sync1   <= `KP_KEY_NONE;
      sync2   <= `KP_KEY_NONE;
      prev    <= `KP_KEY_NONE;
      strobe  <= 1'b0;
      cur_key <= `KP_KEY_NONE;
    end else begin
      sync1  <= key_in;
      sync2  <= sync1;
      prev   <= sync2;
      strobe <= press; // Third edge after key_in changes
      if (press) begin
        cur_key <= sync2; // Held until the next press
      end
    end
  end

  // A strobe must always come with a real key for the FSM
  assert property (@(posedge clk) disable iff (!nRst)
    strobe |-> (cur_key != `KP_KEY_NONE))
    else $error("strobe with empty key code");

endmodule

// File: design/ascii_encoder.sv
`timescale 1ns/100ps
`include "keypad_consts.svh"

module ascii_encoder (
  input  logic [3:0]             row,
  input  logic [3:0]             col,
  input  keypad_pkg::tap_state_t state,
  output logic [7:0]             ascii_character // Zero if no letter
);

  logic [7:0] base;  // First letter of the key
  logic [2:0] count; // Letters on the key, zero for non-letter keys
  logic [2:0] tap;   // Tap index within the key

  // Letter groups of keys 2 to 9
  always_comb begin
    base  = 8'd0;
    count = 3'd0;
    case ({row, col})
      `KP_KEY_2: begin base = `KP_ASCII_A;          count = 3'd3; end // ABC
      `KP_KEY_3: begin base = `KP_ASCII_A + 8'd3;   count = 3'd3; end // DEF
      `KP_KEY_4: begin base = `KP_ASCII_A + 8'd6;   count = 3'd3; end // GHI
      `KP_KEY_5: begin base = `KP_ASCII_A + 8'd9;   count = 3'd3; end // JKL
      `KP_KEY_6: begin base = `KP_ASCII_A + 8'd12;  count = 3'd3; end // MNO
      `KP_KEY_7: begin base = `KP_ASCII_A + 8'd15;  count = 3'd4; end // PQRS
      `KP_KEY_8: begin base = `KP_ASCII_A + 8'd19;  count = 3'd3; end // TUV
      `KP_KEY_9: begin base = `KP_ASCII_A + 8'd22;  count = 3'd4; end // WXYZ
      default: begin
        base  = 8'd0;
        count = 3'd0;
      end
    endcase
  end

  // Tap index, INIT and DONE map past every key
  always_comb begin
    case (state)
      keypad_pkg::S0: tap = 3'd0;
      keypad_pkg::S1: tap = 3'd1;
      keypad_pkg::S2: tap = 3'd2;
      keypad_pkg::S3: tap = 3'd3;
      default:        tap = 3'd7;
    endcase
  end

  assign ascii_character = (tap < count) ? (base + {5'd0, tap}) : 8'd0;

endmodule

// File: design/keypad_fsm.sv
`timescale 1ns/100ps
`include "keypad_consts.svh"

module keypad_fsm (
  input  logic             clk,
  input  logic             nRst,
  input  logic             strobe,
  input  keypad_pkg::key_t cur_key,
  output logic             ready,       // Letter submitted, one cycle
  output logic             game_end,    // Key C pressed
  output logic             word_submit, // Hash pressed
  output logic [7:0]       data         // Letter being selected
);

  keypad_pkg::tap_state_t state, next_state;
  keypad_pkg::key_t       prev_key; // Last letter key pressed
  logic [7:0]             next_data;
  logic [7:0]             enc_char; // Letter for next_state
  logic                   ignored;
  logic                   stop_key;   // Clear or game end
  logic                   letter_key; // Keys 2 to 9
  logic                   repeat_key; // Same letter key while tapping

  // Encoder looks at the state being entered
  ascii_encoder encoder_i (
    .row            (cur_key.row),
    .col            (cur_key.col),
    .state          (next_state),
    .ascii_character(enc_char)
  );

  // Key classes
  always_comb begin
    ignored = (cur_key == `KP_KEY_1) || (cur_key == `KP_KEY_A) ||
              (cur_key == `KP_KEY_B) || (cur_key == `KP_KEY_D) ||
              (cur_key == `KP_KEY_SUBMIT_WORD); // Hash goes straight to the buffer
    stop_key = (cur_key == `KP_KEY_CLEAR) || (cur_key == `KP_KEY_GAME_END);
    letter_key = !ignored && !stop_key && (cur_key != `KP_KEY_SUBMIT_LETTER);
    repeat_key = (cur_key == prev_key) &&
                 (state inside {keypad_pkg::S0, keypad_pkg::S1,
                                keypad_pkg::S2, keypad_pkg::S3});
  end

  assign game_end    = strobe && (cur_key == `KP_KEY_GAME_END);
  assign word_submit = strobe && (cur_key == `KP_KEY_SUBMIT_WORD);

  // Next state
  always_comb begin
    next_state = state; // Hold without a valid press
    if (strobe && !ignored) begin
      if (stop_key) begin
        next_state = keypad_pkg::INIT;
      end else if (cur_key == `KP_KEY_SUBMIT_LETTER) begin
        // Star only submits while a letter is selected, DONE drops to INIT
        if (state == keypad_pkg::INIT || state == keypad_pkg::DONE)
          next_state = keypad_pkg::INIT;
        else
          next_state = keypad_pkg::DONE;
      end else if (repeat_key) begin
        case (state)
          keypad_pkg::S0: next_state = keypad_pkg::S1;
          keypad_pkg::S1: next_state = keypad_pkg::S2;
          keypad_pkg::S2: begin
            if ((cur_key == `KP_KEY_7) || (cur_key == `KP_KEY_9))
              next_state = keypad_pkg::S3; // Fourth letter on 7 and 9
            else
              next_state = keypad_pkg::S0; // Wrap
          end
          default: next_state = keypad_pkg::S0; // S3 wraps
        endcase
      end else begin
        next_state = keypad_pkg::S0; // New key, or first press after INIT/DONE
      end
    end
  end

  // Next preview
  always_comb begin
    next_data = data;
    if (strobe && !ignored) begin
      if (stop_key)
        next_data = 8'd0;
      else if (letter_key)
        next_data = enc_char;
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state    <= keypad_pkg::INIT;
      data     <= 8'd0;
      ready    <= 1'b0;
      prev_key <= `KP_KEY_NONE;
    end else begin
      state <= next_state;
      data  <= next_data;
      ready <= (next_state == keypad_pkg::DONE) && (state != keypad_pkg::DONE); // Entry only
      if (strobe && letter_key) begin
        prev_key <= cur_key; // Ignored keys do not break a tap run
      end
    end
  end

  // Submit and game end come from separate presses
  assert property (@(posedge clk) disable iff (!nRst) !(ready && game_end))
    else $error("ready and game_end in the same cycle");

  assert property (@(posedge clk) disable iff (!nRst)
    state inside {keypad_pkg::INIT, keypad_pkg::S0, keypad_pkg::S1,
                  keypad_pkg::S2, keypad_pkg::S3, keypad_pkg::DONE})
    else $error("illegal tap state encoding");

endmodule

// File: design/word_buffer.sv
`timescale 1ns/100ps
`include "keypad_consts.svh"

module word_buffer (
  input  logic              clk,
  input  logic              nRst,
  input  logic              ready,       // Letter submitted
  input  logic              word_submit, // Emit the word
  input  logic              game_end,
  input  logic [7:0]        data,        // Submitted letter
  output logic              letter_valid,
  output logic              word_valid,
  output logic              game_over,   // Sticky until reset
  output logic [7:0]        letter,
  output keypad_pkg::word_t word
);

  localparam int IDX_W = $clog2(`KP_MAX_LETTERS);

  keypad_pkg::word_t acc; // Word under construction

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      letter_valid <= 1'b0;
      word_valid   <= 1'b0;
      game_over    <= 1'b0;
      letter       <= 8'd0;
      word         <= '0;
      acc          <= '0;
    end else begin
      letter_valid <= 1'b0;
      word_valid   <= 1'b0;
      if (!game_over) begin // Nothing gets through after game end
        if (game_end) begin
          game_over <= 1'b1;
          acc       <= '0;
        end else if (ready) begin
          letter_valid <= 1'b1;
          letter       <= data; // Echo every letter, kept or not
          if (acc.len < `KP_MAX_LETTERS) begin
            acc.letters[acc.len[IDX_W-1:0]] <= data;
            acc.len                         <= acc.len + 4'd1;
          end else begin
            acc.overflow <= 1'b1; // Letter dropped
          end
        end else if (word_submit && (acc.len != 4'd0)) begin
          // Empty submit is dropped
          word_valid <= 1'b1;
          word       <= acc;
          acc        <= '0;
        end
      end
    end
  end

  // Length stays within the letter array
  assert property (@(posedge clk) disable iff (!nRst) acc.len <= `KP_MAX_LETTERS)
    else $error("word length past buffer depth");

endmodule

// File: design/keypad_top.sv
`timescale 1ns/100ps

module keypad_top (
  input  logic              clk,
  input  logic              nRst,
  input  keypad_pkg::key_t  key_in,       // Raw keypad code
  output logic [7:0]        preview,      // Letter being selected
  output logic [7:0]        letter,
  output logic              letter_valid,
  output logic              word_valid,
  output logic              game_over,
  output keypad_pkg::word_t word
);

  logic             strobe;
  keypad_pkg::key_t cur_key;
  logic             ready;
  logic             word_submit;
  logic             game_end;

  // Input side
  key_sync sync_i (
    .clk    (clk),
    .nRst   (nRst),
    .key_in (key_in),
    .strobe (strobe),
    .cur_key(cur_key)
  );

  // Tap FSM, its letter register doubles as the preview
  keypad_fsm fsm_i (
    .clk        (clk),
    .nRst       (nRst),
    .strobe     (strobe),
    .cur_key    (cur_key),
    .ready      (ready),
    .game_end   (game_end),
    .word_submit(word_submit),
    .data       (preview)
  );

  // Output side
  word_buffer buffer_i (
    .clk         (clk),
    .nRst        (nRst),
    .ready       (ready),
    .word_submit (word_submit),
    .game_end    (game_end),
    .data        (preview),
    .letter_valid(letter_valid),
    .word_valid  (word_valid),
    .game_over   (game_over),
    .letter      (letter),
    .word        (word)
  );

endmodule

// File: bench/keypad_tb.sv
`timescale 1ns/100ps
`include "keypad_consts.svh"

module keypad_tb;

  // One driver step from the golden file
  typedef struct packed {
    logic [7:0]  kind; // P press, V preview check, G game_over check
    logic [7:0]  code; // Key code or expected value
    logic [15:0] hold; // Cycles held, then the same released
    logic [15:0] taps; // Repeats of the press
  } step_t;

  logic              clk = 1'b0;
  logic              nRst;
  keypad_pkg::key_t  key_in;
  logic [7:0]        preview;
  logic [7:0]        letter;
  logic              letter_valid;
  logic              word_valid;
  logic              game_over;
  keypad_pkg::word_t word;

  step_t             steps[$];
  logic [7:0]        letter_q[$]; // Letters still to come
  keypad_pkg::word_t word_q[$];   // Words still to come
  int                press_lines = 0;
  int                timeout_cycles = 0; // Zero until the golden file is read
  int                cycle_count = 0;

  keypad_top dut_i (
    .clk         (clk),
    .nRst        (nRst),
    .key_in      (key_in),
    .preview     (preview),
    .letter      (letter),
    .letter_valid(letter_valid),
    .word_valid  (word_valid),
    .game_over   (game_over),
    .word        (word)
  );

  always #10 clk = ~clk; // 20 ns period

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_letter(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("FAIL %0t ns: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %0t ns: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input keypad_pkg::word_t exp, input keypad_pkg::word_t act);
    if (act !== exp) begin
      $display("FAIL %0t ns: word expected len %0d ovf %b letters %h, got len %0d ovf %b letters %h",
               $time, exp.len, exp.overflow, exp.letters, act.len, act.overflow, act.letters);
      abort_run();
    end
  endtask

  // One press, key held then released for hold cycles each
  task automatic press_key(input logic [7:0] code, input int hold);
    key_in = code;
    repeat (hold) @(posedge clk);
    #2 key_in = `KP_KEY_NONE;
    repeat (hold) @(posedge clk);
    #2;
  endtask

  // Steps go to the driver list, letters and words to the monitor queues
  task automatic load_golden();
    int                fd;
    int                n;
    int                a;
    int                b;
    int                c;
    logic [63:0]       letters;
    string             line;
    step_t             step;
    keypad_pkg::word_t exp_word;
    fd = $fopen("bench/keypad_tb_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file bench/keypad_tb_golden.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        step = '0;
        case (line.getc(0))
          "P": begin
            n = $sscanf(line, "P %h %d %d", a, b, c);
            step.kind = "P";
            step.code = a[7:0];
            step.hold = b[15:0];
            step.taps = c[15:0];
            steps.push_back(step);
            press_lines++;
          end
          "V", "G": begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h", a) + 2; // Match the P count
            step.kind = line.getc(0);
            step.code = a[7:0];
            steps.push_back(step);
          end
          "L": begin
            n = $sscanf(line, "L %h", a) + 2;
            letter_q.push_back(a[7:0]);
          end
          "W": begin
            n = $sscanf(line, "W %d %d %h", a, b, letters);
            exp_word.letters  = letters;
            exp_word.len      = a[3:0];
            exp_word.overflow = b[0];
            word_q.push_back(exp_word);
          end
          default: n = 0;
        endcase
        if (n != 3) begin
          $display("Malformed golden line: %s", line);
          abort_run();
        end
      end
    end
    $fclose(fd);
  endtask

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the key sequence never finished", cycle_count);
      abort_run();
    end
  end

  // Outputs sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (nRst && letter_valid) begin
      if (letter_q.size() == 0) begin
        $display("Unexpected letter %h at %0t ns, none was due", letter, $time);
        abort_run();
      end else begin
        check_letter("letter", letter_q.pop_front(), letter);
      end
    end
    if (nRst && word_valid) begin
      if (word_q.size() == 0) begin
        $display("Unexpected word of length %0d at %0t ns, none was due", word.len, $time);
        abort_run();
      end else begin
        check_word(word_q.pop_front(), word);
      end
    end
  end

  initial begin
    key_in = `KP_KEY_NONE;
    nRst   = 1'b0;
    load_golden();
    timeout_cycles = press_lines * 16 + 50;
    repeat (4) @(posedge clk); // Reset held for 4 cycles
    #2 nRst = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      case (steps[i].kind)
        "P":     repeat (steps[i].taps) press_key(steps[i].code, steps[i].hold);
        "V":     check_letter("preview", steps[i].code, preview);
        default: check_flag("game_over", steps[i].code[0], game_over);
      endcase
    end
    if (letter_q.size() != 0 || word_q.size() != 0) begin
      $display("Sequence ended with %0d letters and %0d words never produced",
               letter_q.size(), word_q.size());
      abort_run();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: build.f
+incdir+design
design/keypad_pkg.sv
design/key_sync.sv
design/ascii_encoder.sv
design/keypad_fsm.sv
design/word_buffer.sv
design/keypad_top.sv
bench/keypad_tb.sv

// File: bench/keypad_tb_golden.txt
# P key hold taps: press key (hex) taps times, each held then released for hold cycles
# V preview (hex), L letter (hex), W len overflow letters (hex, letter 0 low), G game_over
P 84 4 1
V 41
P 84 4 1
V 42
P 84 4 1
V 43
P 18 4 1
L 43
P 28 4 4
V 53
P 18 4 1
L 53
P 28 5 5
V 50
P 18 4 1
L 50
P 12 4 1
W 3 0 0000000000505343
P 84 4 1
V 41
P 14 4 1
V 00
P 18 4 1
P 48 4 1
V 47
P 48 4 1
V 48
P 88 4 1
P 81 4 1
V 48
P 48 4 1
V 49
P 44 4 1
V 4A
P 14 4 1
P 48 4 2
P 18 4 1
L 48
P 48 4 3
P 18 4 1
L 49
P 12 4 1
W 2 0 0000000000004948
P 12 4 1
P 84 4 1
P 18 4 1
L 41
P 82 4 1
P 18 4 1
L 44
P 48 4 1
P 18 4 1
L 47
P 44 4 1
P 18 4 1
L 4A
P 42 4 1
P 18 4 1
L 4D
P 28 4 1
P 18 4 1
L 50
P 24 4 1
P 18 4 1
L 54
P 22 4 1
P 18 4 1
L 57
P 84 4 1
P 18 4 1
L 41
P 12 4 1
W 8 1 5754504D4A474441
G 0
P 21 4 1
G 1
V 00
P 84 4 1
P 18 4 1
P 12 4 1
G 1
